/* Makefile */
# Verilator build and run for the frame header parser testbench

TOP        ?= frame_header_parser_tb
FILELIST   ?= frame_header_parser.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

PASS_MSG := *** PASSED ***
SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the exit code of the simulator
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* frame_header_parser.f */
hw/frame_parse_pkg.sv
hw/parse_common_frame_table.sv
hw/parse_big_field_table.sv
hw/stream_reg_slice.sv
hw/frame_header_parser.sv
sim/frame_header_parser_checker.sv
sim/frame_header_parser_tb.sv

/* hw/frame_header_parser.sv */
// Frames must be longer than the type field when it is stripped, else the key count runs on
`default_nettype none
`timescale 1ns/100ps

module frame_header_parser #(
   parameter bit type_strip = 1'b1,
   parameter int key_bytes  = 6,
   parameter bit key_strip  = 1'b1
) (
   input  wire                           aclk,
   input  wire                           reset,
   input  wire                           enable,

   // Input stream
   input  wire frame_parse_pkg::stream_beat_t s_beat,
   input  wire                           s_valid,
   output logic                          s_ready,

   // Output stream
   output frame_parse_pkg::stream_beat_t m_beat,
   output logic                          m_valid,
   input  wire                           m_ready,

   // Extracted fields
   output frame_parse_pkg::type_field_t  type_value,
   output logic                          type_done,
   output frame_parse_pkg::field_value_t key_value,
   output logic                          key_done
);

   import frame_parse_pkg::*;

   localparam int type_bits  = $bits(type_field_t);
   localparam int type_bytes = type_bits / byte_bits;

   field_value_t type_table_value;

   // Type extractor to key extractor
   stream_beat_t t2k_beat;
   logic         t2k_valid;
   logic         t2k_ready;

   // Key extractor to output slice
   stream_beat_t k2o_beat;
   logic         k2o_valid;
   logic         k2o_ready;

   // ------------------------------
   // Type field, head of frame
   // ------------------------------
   parse_common_frame_table #(
      .field_bytes (type_bytes),
      .strip       (type_strip)
   ) type_table0 (
      .aclk      (aclk),
      .reset     (reset),
      .enable    (enable),
      .in_beat   (s_beat),
      .in_valid  (s_valid),
      .in_ready  (s_ready),
      .out_beat  (t2k_beat),
      .out_valid (t2k_valid),
      .out_ready (t2k_ready),
      .value     (type_table_value),
      .done      (type_done)
   );

   // Only the top two bytes carry the type
   assign type_value = type_table_value[$bits(field_value_t)-1 -: type_bits];

   // ------------------------------
   // Key field, counted after the type
   // ------------------------------
   parse_big_field_table #(
      .field_bytes (key_bytes),
      .strip       (key_strip)
   ) key_table0 (
      .aclk      (aclk),
      .reset     (reset),
      .enable    (enable),
      .in_beat   (t2k_beat),
      .in_valid  (t2k_valid),
      .in_ready  (t2k_ready),
      .out_beat  (k2o_beat),
      .out_valid (k2o_valid),
      .out_ready (k2o_ready),
      .key       (key_value),
      .key_valid (key_done)
   );

   // Registered output, one cycle after acceptance
   stream_reg_slice #(
      .payload_t (stream_beat_t)
   ) out_slice0 (
      .aclk      (aclk),
      .reset     (reset),
      .in_data   (k2o_beat),
      .in_valid  (k2o_valid),
      .in_ready  (k2o_ready),
      .out_data  (m_beat),
      .out_valid (m_valid),
      .out_ready (m_ready)
   );

endmodule : frame_header_parser

`default_nettype wire

/* hw/frame_parse_pkg.sv */
// One byte per beat only; a field holds at most field_max_bytes bytes, byte 0 in the top byte
`default_nettype none

package frame_parse_pkg;

   // ------------------------------
   // Beat and field limits
   // ------------------------------

   // Width of one stream beat's data
   localparam int byte_bits = 8;

   // Largest field a single extractor can capture
   localparam int field_max_bytes = 16;

   // Counter wide enough to hold field_max_bytes itself
   localparam int count_bits = $clog2(field_max_bytes + 1);

   // ------------------------------
   // Field types
   // ------------------------------

   // Byte position within the head of a frame
   typedef logic [count_bits-1:0] field_count_t;

   // Captured field, left-aligned
   // Byte 0 of the field sits in bits [127:120]
   typedef logic [field_max_bytes*byte_bits-1:0] field_value_t;

   // Short type field at the head of every frame
   typedef logic [2*byte_bits-1:0] type_field_t;

   // ------------------------------
   // Stream beat
   // ------------------------------

   // One beat on every valid/ready link
   // last marks the final byte of a frame
   typedef struct packed {
      logic [byte_bits-1:0] data;
      logic                 last;
   } stream_beat_t;

endpackage : frame_parse_pkg

`default_nettype wire

/* hw/parse_big_field_table.sv */
// Keys of 1..16 bytes only; key is right-aligned, upper bytes read as zero
`default_nettype none
`timescale 1ns/100ps

module parse_big_field_table #(
   parameter int field_bytes = 16,
   parameter bit strip       = 1'b1
) (
   input  wire                           aclk,
   input  wire                           reset,
   input  wire                           enable,

   // Upstream
   input  wire frame_parse_pkg::stream_beat_t in_beat,
   input  wire                           in_valid,
   output logic                          in_ready,

   // Downstream
   output frame_parse_pkg::stream_beat_t out_beat,
   output logic                          out_valid,
   input  wire                           out_ready,

   // Key as a plain number
   output frame_parse_pkg::field_value_t key,
   output logic                          key_valid
);

   import frame_parse_pkg::*;

   // Distance from left-aligned table value to right-aligned key
   localparam int align_bits = (field_max_bytes - field_bytes) * byte_bits;

   field_value_t table_value;

   generate
      if (field_bytes < 1 || field_bytes > field_max_bytes) begin : g_size_check
         $error("field_bytes %0d outside 1..%0d", field_bytes, field_max_bytes);
      end
   endgenerate

   parse_common_frame_table #(
      .field_bytes (field_bytes),
      .strip       (strip)
   ) table0 (
      .aclk      (aclk),
      .reset     (reset),
      .enable    (enable),
      .in_beat   (in_beat),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_beat  (out_beat),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .value     (table_value),
      .done      (key_valid)
   );

   // Pad bytes below the key are zero, so they shift out cleanly
   assign key = table_value >> align_bits;

endmodule : parse_big_field_table

`default_nettype wire

/* hw/parse_common_frame_table.sv */
// field_bytes must be 1..16; a frame that ends inside the field leaves value unchanged, no error flag
`default_nettype none
`timescale 1ns/100ps

module parse_common_frame_table #(
   parameter int field_bytes = 2,
   parameter bit strip       = 1'b1
) (
   input  wire                           aclk,
   input  wire                           reset,
   input  wire                           enable,

   // Upstream
   input  wire frame_parse_pkg::stream_beat_t in_beat,
   input  wire                           in_valid,
   output logic                          in_ready,

   // Downstream
   output frame_parse_pkg::stream_beat_t out_beat,
   output logic                          out_valid,
   input  wire                           out_ready,

   // Captured field
   output frame_parse_pkg::field_value_t value,
   output logic                          done
);

   import frame_parse_pkg::*;

   localparam field_count_t field_count = field_count_t'(field_bytes);
   localparam field_count_t last_count  = field_count_t'(field_bytes - 1);

   // Shift that moves the newest field_bytes bytes up to the top
   localparam int pad_bits = (field_max_bytes - field_bytes) * byte_bits;

   field_count_t count_q;
   logic         sof_q;
   logic         en_q;
   logic         en_frame;
   logic         is_field;
   logic         hold_beat;
   logic         in_fire;
   logic         field_end;
   field_value_t acc_q;
   field_value_t acc_next;

   // ------------------------------
   // Beat classification
   // ------------------------------

   // enable counts only at the first beat, then the latched copy rules
   assign en_frame = sof_q ? enable : en_q;

   // Count saturates at field_bytes, so later bytes are payload
   assign is_field  = en_frame && (count_q < field_count);
   assign hold_beat = strip && is_field;

   // Forwarded beats pass straight through
   assign out_beat  = in_beat;
   assign out_valid = in_valid && !hold_beat;

   // Stripped bytes are swallowed whatever downstream does
   assign in_ready = hold_beat || out_ready;
   assign in_fire  = in_valid && in_ready;

   assign field_end = in_fire && is_field && (count_q == last_count);

   // ------------------------------
   // Frame tracking
   // ------------------------------
   always_ff @(posedge aclk) begin
      if (reset) begin
         sof_q   <= 1'b1;
         en_q    <= 1'b0;
         count_q <= '0;
      end else if (in_fire) begin
         sof_q <= in_beat.last;
         if (sof_q) begin
            en_q <= enable;
         end
         if (in_beat.last) begin
            count_q <= '0;
         end else if (is_field) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   // ------------------------------
   // Field capture
   // ------------------------------

   // Arrival order, newest byte at the bottom
   assign acc_next = {acc_q[field_max_bytes*byte_bits-byte_bits-1:0], in_beat.data};

   always_ff @(posedge aclk) begin
      if (in_fire && is_field) begin
         acc_q <= acc_next;
      end
   end

   // Value only moves on a complete field
   // Left-aligned so byte 0 lands in the top byte
   always_ff @(posedge aclk) begin
      if (reset) begin
         value <= '0;
         done  <= 1'b0;
      end else begin
         done <= field_end;
         if (field_end) begin
            value <= acc_next << pad_bits;
         end
      end
   end

endmodule : parse_common_frame_table

`default_nettype wire

/* hw/stream_reg_slice.sv */
// Single entry; payload_t must be a packed type; out_data is undefined while out_valid is low
`default_nettype none
`timescale 1ns/100ps

module stream_reg_slice #(
   parameter type payload_t = frame_parse_pkg::stream_beat_t
) (
   input  wire      aclk,
   input  wire      reset,

   // Upstream
   input  wire payload_t in_data,
   input  wire      in_valid,
   output logic     in_ready,

   // Downstream
   output payload_t out_data,
   output logic     out_valid,
   input  wire      out_ready
);

   payload_t data_q;
   logic     valid_q;
   logic     in_fire;

   // ------------------------------
   // Handshake
   // ------------------------------

   // Room when empty, or when the held beat leaves this cycle
   assign in_ready = !valid_q || out_ready;
   assign in_fire  = in_valid && in_ready;

   assign out_data  = data_q;
   assign out_valid = valid_q;

   // ------------------------------
   // Storage
   // ------------------------------

   // Occupancy
   always_ff @(posedge aclk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else if (in_fire) begin
         valid_q <= 1'b1;
      end else if (out_ready) begin
         valid_q <= 1'b0;
      end
   end

   // Reload in the same cycle the old beat is taken
   always_ff @(posedge aclk) begin
      if (in_fire) begin
         data_q <= in_data;
      end
   end

endmodule : stream_reg_slice

`default_nettype wire

/* sim/frame_header_parser_checker.sv */
// Top-level output and done-pulse assertions only; m_ready is assumed driven between clock edges
`default_nettype none
`timescale 1ns/100ps

module frame_header_parser_checker (
   input wire                                aclk,
   input wire                                reset,
   input wire frame_parse_pkg::stream_beat_t m_beat,
   input wire                                m_valid,
   input wire                                m_ready,
   input wire                                type_done,
   input wire                                key_done
);

   // ------------------------------
   // Output stream
   // ------------------------------

   // A stalled beat stays put until taken
   out_hold: assert property (@(posedge aclk) disable iff (reset)
      m_valid && !m_ready |=> m_valid && $stable(m_beat))
      else $error("m_beat changed or dropped while m_valid was high and m_ready low");

   out_reset: assert property (@(posedge aclk) reset |=> !m_valid)
      else $error("m_valid high in the cycle after reset");

   // ------------------------------
   // Done pulses
   // ------------------------------
   type_pulse: assert property (@(posedge aclk) disable iff (reset)
      type_done |=> !type_done)
      else $error("type_done held high for more than one cycle");

   key_pulse: assert property (@(posedge aclk) disable iff (reset)
      key_done |=> !key_done)
      else $error("key_done held high for more than one cycle");

endmodule : frame_header_parser_checker

`default_nettype wire

/* sim/frame_header_parser_tb.sv */
// Directed tests for one build only with type and 6-byte key both stripped and one byte per beat
`default_nettype none
`timescale 1ns/100ps

module frame_header_parser_tb;

   import frame_parse_pkg::*;

   typedef logic [7:0] byte_q_t[$];

   // Roughly twice the summed length of all tests
   localparam int max_cycles = 4000;

   logic         aclk;
   logic         reset;
   logic         enable;
   stream_beat_t s_beat;
   logic         s_valid;
   logic         s_ready;
   stream_beat_t m_beat;
   logic         m_valid;
   logic         m_ready;
   type_field_t  type_value;
   logic         type_done;
   field_value_t key_value;
   logic         key_done;

   logic [31:0]  lfsr_q = 32'd93739;
   int           cycle_count = 0;
   int           check_count = 0;
   int           error_count = 0;
   int           test_count = 0;
   int           test_errors = 0;
   logic         ready_q[$];

   // Expected and observed traffic
   stream_beat_t exp_out[$];
   stream_beat_t got_out[$];
   int           exp_cycle[$];
   int           got_cycle[$];
   type_field_t  exp_type[$];
   type_field_t  got_type[$];
   field_value_t exp_key[$];
   field_value_t got_key[$];
   type_field_t  held_type = '0;
   field_value_t held_key = '0;

   frame_header_parser #(
      .type_strip (1'b1),
      .key_bytes  (6),
      .key_strip  (1'b1)
   ) dut0 (.*);

   bind frame_header_parser frame_header_parser_checker checker0 (
      .aclk      (aclk),
      .reset     (reset),
      .m_beat    (m_beat),
      .m_valid   (m_valid),
      .m_ready   (m_ready),
      .type_done (type_done),
      .key_done  (key_done)
   );

   // ------------------------------
   // Clock, timeout, monitors
   // ------------------------------
   initial begin
      aclk = 1'b0;
      forever #4 aclk = ~aclk;
   end

   always @(posedge aclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == max_cycles) begin
         $display("Timeout: run still busy after %0d cycles", max_cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // Stall pattern when one is queued and always ready otherwise
   initial begin
      m_ready = 1'b1;
      forever begin
         @(posedge aclk);
         #1;
         m_ready = (ready_q.size() > 0) ? ready_q.pop_front() : 1'b1;
      end
   end

   // Collect output beats and done pulses
   always @(negedge aclk) begin
      if (!reset && m_valid && m_ready) begin
         got_out.push_back(m_beat);
         got_cycle.push_back(cycle_count);
      end
      if (!reset && type_done) begin
         got_type.push_back(type_value);
      end
      if (!reset && key_done) begin
         got_key.push_back(key_value);
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic int payload_len();
      return 1 + int'(random_bits(5));
   endfunction

   function automatic byte_q_t make_frame(input int len);
      byte_q_t q;
      for (int i = 0; i < len; i++) begin
         q.push_back(8'(random_bits(8)));
      end
      return q;
   endfunction

   task automatic check(input bit ok, input string msg);
      check_count++;
      assert (ok) else begin
         $display("CHECK FAILED at %0t ns: %s", $time, msg);
         error_count++;
         test_errors++;
      end
   endtask

   // ------------------------------
   // Frame driver and scoreboard
   // ------------------------------
   task automatic send_frame(input byte_q_t bytes, input bit en);
      int           head;
      bit           taken;
      field_value_t key;
      stream_beat_t beat;
      head = en ? 8 : 0;
      if (en && bytes.size() >= 2) begin
         held_type = {bytes[0], bytes[1]};
         exp_type.push_back(held_type);
      end
      // Key is bytes 2..7 right-aligned
      if (en && bytes.size() >= 8) begin
         key = '0;
         for (int j = 2; j < 8; j++) begin
            key = (key << 8) | field_value_t'(bytes[j]);
         end
         held_key = key;
         exp_key.push_back(key);
      end
      foreach (bytes[i]) begin
         beat.data = bytes[i];
         beat.last = (i == bytes.size() - 1);
         s_beat    = beat;
         s_valid   = 1'b1;
         enable    = en;
         taken     = 1'b0;
         while (!taken) begin
            @(negedge aclk);
            taken = s_ready;
            // Header bytes are swallowed even while the output stalls
            if (i < head) begin
               check(taken, $sformatf("header byte %0d held back by output stall", i));
            end
            if (taken && i >= head) begin
               exp_out.push_back(beat);
               exp_cycle.push_back(cycle_count);
            end
            @(posedge aclk);
            #1;
         end
      end
   endtask

   task automatic start_test();
      test_errors = 0;
      exp_out.delete();
      got_out.delete();
      exp_cycle.delete();
      got_cycle.delete();
      exp_type.delete();
      got_type.delete();
      exp_key.delete();
      got_key.delete();
   endtask

   task automatic finish_test(input string name, input bit timed);
      s_valid = 1'b0;
      while (got_out.size() < exp_out.size()) begin
         @(posedge aclk);
      end
      // Room for stray beats or late done pulses
      repeat (8) @(posedge aclk);
      @(negedge aclk);
      ready_q.delete();
      check(got_out.size() == exp_out.size(),
         $sformatf("%0d output beats, expected %0d", got_out.size(), exp_out.size()));
      check(got_type.size() == exp_type.size(),
         $sformatf("%0d type_done pulses, expected %0d", got_type.size(), exp_type.size()));
      check(got_key.size() == exp_key.size(),
         $sformatf("%0d key_done pulses, expected %0d", got_key.size(), exp_key.size()));
      foreach (exp_out[i]) begin
         if (i < got_out.size()) begin
            check(got_out[i] == exp_out[i], $sformatf("beat %0d is %h last %b, expected %h last %b",
               i, got_out[i].data, got_out[i].last, exp_out[i].data, exp_out[i].last));
            if (timed) begin
               check(got_cycle[i] - exp_cycle[i] == 1, $sformatf("beat %0d left after %0d cycles",
                  i, got_cycle[i] - exp_cycle[i]));
            end
         end
      end
      foreach (exp_type[i]) begin
         if (i < got_type.size()) begin
            check(got_type[i] == exp_type[i],
               $sformatf("type %0d is %h, expected %h", i, got_type[i], exp_type[i]));
         end
      end
      foreach (exp_key[i]) begin
         if (i < got_key.size()) begin
            check(got_key[i] == exp_key[i],
               $sformatf("key %0d is %h, expected %h", i, got_key[i], exp_key[i]));
         end
      end
      // Held values belong to the last complete field
      check(type_value == held_type, $sformatf("held type %h, expected %h", type_value, held_type));
      check(key_value == held_key, $sformatf("held key %h, expected %h", key_value, held_key));
      test_count++;
      $display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad", test_errors);
      @(posedge aclk);
      #1;
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic parse_field_values();
      start_test();
      repeat (4) send_frame(make_frame(8 + payload_len()), 1'b1);
      finish_test("field_values", 1'b0);
   endtask

   task automatic strip_headers();
      start_test();
      send_frame(make_frame(9), 1'b1);
      repeat (7) send_frame(make_frame(8 + payload_len()), 1'b1);
      finish_test("stripping", 1'b0);
   endtask

   task automatic stall_output();
      start_test();
      @(negedge aclk);
      for (int i = 0; i < 900; i++) begin
         ready_q.push_back(random_bits(2) != 2'b00);
      end
      @(posedge aclk);
      #1;
      repeat (20) send_frame(make_frame(8 + payload_len()), 1'b1);
      finish_test("back_pressure", 1'b0);
   endtask

   task automatic pass_disabled_frames();
      start_test();
      repeat (4) send_frame(make_frame(4 + payload_len()), 1'b0);
      finish_test("enable_low", 1'b0);
   endtask

   // 4-byte frame ends inside the key
   task automatic recover_short_frame();
      start_test();
      send_frame(make_frame(4), 1'b1);
      send_frame(make_frame(8 + payload_len()), 1'b1);
      finish_test("short_frame", 1'b0);
   endtask

   task automatic measure_latency();
      start_test();
      repeat (6) send_frame(make_frame(8 + payload_len()), 1'b1);
      finish_test("latency", 1'b1);
   endtask

   initial begin
      reset   = 1'b1;
      enable  = 1'b0;
      s_beat  = '0;
      s_valid = 1'b0;
      repeat (3) @(posedge aclk);
      #1;
      reset = 1'b0;
      parse_field_values();
      strip_headers();
      stall_output();
      pass_disabled_frames();
      recover_short_frame();
      measure_latency();
      $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule : frame_header_parser_tb

`default_nettype wire
